/* verilog/rvcore_defines.svh */
// shared widths, reset address and major opcodes for the rv64i core and its testbench
`ifndef RVCORE_DEFINES_SVH
`define RVCORE_DEFINES_SVH

// data path
`define CPU_WIDTH       64              // xlen of the core
`define REG_ADDR_WIDTH  5               // 32 architectural registers

// first fetch after reset
`define RESET_PC        64'h8000_0000

// major opcodes, inst[6:0]
`define OPC_OP          7'b0110011      // register-register alu
`define OPC_OP_IMM      7'b0010011      // register-immediate alu
`define OPC_LUI         7'b0110111
`define OPC_AUIPC       7'b0010111
`define OPC_JAL         7'b1101111
`define OPC_JALR        7'b1100111
`define OPC_BRANCH      7'b1100011      // conditional branches

`endif

/* verilog/rvcore_pkg.sv */
// types shared by the core modules, referenced as rvcore_pkg::name
`default_nettype none

`include "rvcore_defines.svh"

package rvcore_pkg;

    typedef logic [`CPU_WIDTH-1:0]      xlen_t;      // register or pc value
    typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;  // register index
    typedef logic [31:0]                inst_t;      // raw instruction word

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLTU
    } alu_op_e;

    typedef enum logic [2:0] {
        IMM_I, IMM_S, IMM_B, IMM_U, IMM_J
    } imm_type_e;

    typedef enum logic [0:0] {SRC1_REG, SRC1_PC} src1_sel_e;
    typedef enum logic [1:0] {SRC2_REG, SRC2_IMM, SRC2_FOUR} src2_sel_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
    } br_cond_e;

    // decoded control for one instruction
    typedef struct packed {
        logic      reg_wen;
        reg_addr_t reg_waddr;
        reg_addr_t reg1_raddr;
        reg_addr_t reg2_raddr;
        alu_op_e   alu_op;
        src1_sel_e src1_sel;
        src2_sel_e src2_sel;
        imm_type_e imm_type;
        br_cond_e  br_cond;
        logic      jump;      // jal
        logic      jump_reg;  // jalr
    } ctrl_t;

    // one retired instruction as seen at the top level
    typedef struct packed {
        logic      valid;
        logic      reg_wen;
        reg_addr_t reg_waddr;
        xlen_t     reg_wdata;
    } commit_t;

endpackage

`default_nettype wire

/* verilog/pc_unit.sv */
// program counter with next-pc selection, steered by the decoder and the branch compare
`timescale 1ns/10ps
`default_nettype none

`include "rvcore_defines.svh"

module pc_unit (
    input  logic              clk,
    input  logic              arst_n,
    input  rvcore_pkg::ctrl_t ctrl,
    input  rvcore_pkg::xlen_t imm,
    input  rvcore_pkg::xlen_t reg1_rdata,
    input  logic              br_taken,
    output rvcore_pkg::xlen_t pc
);

    rvcore_pkg::xlen_t pc_seq;   // fall through
    rvcore_pkg::xlen_t pc_rel;   // branch and jal target
    rvcore_pkg::xlen_t reg_rel;  // jalr target
    rvcore_pkg::xlen_t next_pc;
    logic              branch;

    assign pc_seq  = pc + rvcore_pkg::xlen_t'(4);
    assign pc_rel  = pc + imm;
    assign reg_rel = (reg1_rdata + imm) & ~rvcore_pkg::xlen_t'(1);  // lsb forced low
    assign branch  = (ctrl.br_cond != rvcore_pkg::BR_NONE) && br_taken;

    always_comb begin
        if (ctrl.jump_reg) begin
            next_pc = reg_rel;
        end else if (ctrl.jump || branch) begin
            next_pc = pc_rel;
        end else begin
            next_pc = pc_seq;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= `RESET_PC;
        end else begin
            pc <= next_pc;  // one instruction per edge
        end
    end

endmodule

`default_nettype wire

/* verilog/inst_decoder.sv */
// rv64i decoder producing the control word and the sign-extended immediate
`timescale 1ns/10ps
`default_nettype none

`include "rvcore_defines.svh"

module inst_decoder (
    input  rvcore_pkg::inst_t inst,
    output rvcore_pkg::ctrl_t ctrl,
    output rvcore_pkg::xlen_t imm,
    output logic              unknown_code
);

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    rvcore_pkg::reg_addr_t rd;
    logic                  writes_rd;  // class has a destination register

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rd     = inst[11:7];

    always_comb begin
        ctrl.reg_waddr  = rd;
        ctrl.reg1_raddr = inst[19:15];
        ctrl.reg2_raddr = inst[24:20];
        ctrl.alu_op     = rvcore_pkg::ALU_ADD;
        ctrl.src1_sel   = rvcore_pkg::SRC1_REG;
        ctrl.src2_sel   = rvcore_pkg::SRC2_REG;
        ctrl.imm_type   = rvcore_pkg::IMM_I;
        ctrl.br_cond    = rvcore_pkg::BR_NONE;
        ctrl.jump       = 1'b0;
        ctrl.jump_reg   = 1'b0;
        writes_rd       = 1'b0;
        unknown_code    = 1'b0;

        case (opcode)
            `OPC_OP: begin
                writes_rd = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: ctrl.alu_op = rvcore_pkg::ALU_ADD;
                    10'b0100000_000: ctrl.alu_op = rvcore_pkg::ALU_SUB;
                    10'b0000000_010: ctrl.alu_op = rvcore_pkg::ALU_SLT;
                    10'b0000000_011: ctrl.alu_op = rvcore_pkg::ALU_SLTU;
                    10'b0000000_100: ctrl.alu_op = rvcore_pkg::ALU_XOR;
                    10'b0000000_110: ctrl.alu_op = rvcore_pkg::ALU_OR;
                    10'b0000000_111: ctrl.alu_op = rvcore_pkg::ALU_AND;
                    default:         unknown_code = 1'b1;  // shifts and m-extension
                endcase
            end
            `OPC_OP_IMM: begin
                writes_rd     = 1'b1;
                ctrl.src2_sel = rvcore_pkg::SRC2_IMM;
                case (funct3)
                    3'b000:  ctrl.alu_op = rvcore_pkg::ALU_ADD;
                    3'b010:  ctrl.alu_op = rvcore_pkg::ALU_SLT;
                    3'b011:  ctrl.alu_op = rvcore_pkg::ALU_SLTU;
                    3'b100:  ctrl.alu_op = rvcore_pkg::ALU_XOR;
                    3'b110:  ctrl.alu_op = rvcore_pkg::ALU_OR;
                    3'b111:  ctrl.alu_op = rvcore_pkg::ALU_AND;
                    default: unknown_code = 1'b1;  // slli, srli, srai
                endcase
            end
            `OPC_LUI: begin
                writes_rd       = 1'b1;
                ctrl.reg1_raddr = '0;  // x0 as the zero operand
                ctrl.src2_sel   = rvcore_pkg::SRC2_IMM;
                ctrl.imm_type   = rvcore_pkg::IMM_U;
            end
            `OPC_AUIPC: begin
                writes_rd     = 1'b1;
                ctrl.src1_sel = rvcore_pkg::SRC1_PC;
                ctrl.src2_sel = rvcore_pkg::SRC2_IMM;
                ctrl.imm_type = rvcore_pkg::IMM_U;
            end
            `OPC_JAL: begin
                writes_rd     = 1'b1;
                ctrl.src1_sel = rvcore_pkg::SRC1_PC;
                ctrl.src2_sel = rvcore_pkg::SRC2_FOUR;  // link value
                ctrl.imm_type = rvcore_pkg::IMM_J;
                ctrl.jump     = 1'b1;
            end
            `OPC_JALR: begin
                if (funct3 == 3'b000) begin
                    writes_rd     = 1'b1;
                    ctrl.src1_sel = rvcore_pkg::SRC1_PC;
                    ctrl.src2_sel = rvcore_pkg::SRC2_FOUR;
                    ctrl.jump_reg = 1'b1;
                end else begin
                    unknown_code = 1'b1;
                end
            end
            `OPC_BRANCH: begin
                ctrl.imm_type = rvcore_pkg::IMM_B;
                case (funct3)
                    3'b000:  ctrl.br_cond = rvcore_pkg::BR_EQ;
                    3'b001:  ctrl.br_cond = rvcore_pkg::BR_NE;
                    3'b100:  ctrl.br_cond = rvcore_pkg::BR_LT;
                    3'b101:  ctrl.br_cond = rvcore_pkg::BR_GE;
                    3'b110:  ctrl.br_cond = rvcore_pkg::BR_LTU;
                    3'b111:  ctrl.br_cond = rvcore_pkg::BR_GEU;
                    default: unknown_code = 1'b1;
                endcase
            end
            default: unknown_code = 1'b1;  // loads, stores, system, w-forms
        endcase

        // x0 writes and unknown codes retire without a register write
        ctrl.reg_wen = writes_rd && (rd != '0) && !unknown_code;
    end

    always_comb begin
        case (ctrl.imm_type)
            rvcore_pkg::IMM_B: imm = {{(`CPU_WIDTH-12){inst[31]}}, inst[7], inst[30:25],
                                      inst[11:8], 1'b0};
            rvcore_pkg::IMM_U: imm = {{(`CPU_WIDTH-32){inst[31]}}, inst[31:12], 12'b0};
            rvcore_pkg::IMM_J: imm = {{(`CPU_WIDTH-20){inst[31]}}, inst[19:12], inst[20],
                                      inst[30:21], 1'b0};
            default:           imm = {{(`CPU_WIDTH-12){inst[31]}}, inst[31:20]};  // I type
        endcase
    end

endmodule

`default_nettype wire

/* verilog/reg_file.sv */
// integer register file, two combinational reads and one write per clock edge
`timescale 1ns/10ps
`default_nettype none

module reg_file (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  wen,
    input  rvcore_pkg::reg_addr_t waddr,
    input  rvcore_pkg::xlen_t     wdata,
    input  rvcore_pkg::reg_addr_t raddr1,
    input  rvcore_pkg::reg_addr_t raddr2,
    output rvcore_pkg::xlen_t     rdata1,
    output rvcore_pkg::xlen_t     rdata2
);

    rvcore_pkg::xlen_t regs [1:31];  // x0 has no storage

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    always_comb begin
        if (raddr1 == '0) begin
            rdata1 = '0;  // x0 reads as zero
        end else begin
            rdata1 = regs[raddr1];
        end
    end

    always_comb begin
        if (raddr2 == '0) begin
            rdata2 = '0;
        end else begin
            rdata2 = regs[raddr2];
        end
    end

endmodule

`default_nettype wire

/* verilog/alu.sv */
// operand selection, integer alu and branch condition evaluation
`timescale 1ns/10ps
`default_nettype none

module alu (
    input  rvcore_pkg::ctrl_t ctrl,
    input  rvcore_pkg::xlen_t reg1_rdata,
    input  rvcore_pkg::xlen_t reg2_rdata,
    input  rvcore_pkg::xlen_t imm,
    input  rvcore_pkg::xlen_t pc,
    output rvcore_pkg::xlen_t alu_res,
    output logic              br_taken
);

    rvcore_pkg::xlen_t src1;
    rvcore_pkg::xlen_t src2;
    logic              eq;
    logic              lt_s;
    logic              lt_u;

    // lui arrives with reg1 index 0, so src1 is zero on the add path
    assign src1 = (ctrl.src1_sel == rvcore_pkg::SRC1_PC) ? pc : reg1_rdata;

    always_comb begin
        case (ctrl.src2_sel)
            rvcore_pkg::SRC2_IMM:  src2 = imm;
            rvcore_pkg::SRC2_FOUR: src2 = rvcore_pkg::xlen_t'(4);  // jal/jalr link
            default:               src2 = reg2_rdata;
        endcase
    end

    always_comb begin
        case (ctrl.alu_op)
            rvcore_pkg::ALU_SUB:  alu_res = src1 - src2;
            rvcore_pkg::ALU_AND:  alu_res = src1 & src2;
            rvcore_pkg::ALU_OR:   alu_res = src1 | src2;
            rvcore_pkg::ALU_XOR:  alu_res = src1 ^ src2;
            rvcore_pkg::ALU_SLT:  alu_res = rvcore_pkg::xlen_t'($signed(src1) < $signed(src2));
            rvcore_pkg::ALU_SLTU: alu_res = rvcore_pkg::xlen_t'(src1 < src2);
            default:              alu_res = src1 + src2;
        endcase
    end

    // branch compare always works on the two register values
    assign eq   = (reg1_rdata == reg2_rdata);
    assign lt_s = ($signed(reg1_rdata) < $signed(reg2_rdata));
    assign lt_u = (reg1_rdata < reg2_rdata);

    always_comb begin
        case (ctrl.br_cond)
            rvcore_pkg::BR_EQ:  br_taken = eq;
            rvcore_pkg::BR_NE:  br_taken = !eq;
            rvcore_pkg::BR_LT:  br_taken = lt_s;
            rvcore_pkg::BR_GE:  br_taken = !lt_s;
            rvcore_pkg::BR_LTU: br_taken = lt_u;
            rvcore_pkg::BR_GEU: br_taken = !lt_u;
            default:            br_taken = 1'b0;  // not a branch
        endcase
    end

endmodule

`default_nettype wire

/* verilog/rvcore_top.sv */
// single-cycle rv64i core top, fetches through pc/inst and reports each retirement on commit
`timescale 1ns/10ps
`default_nettype none

module rvcore_top (
    input  logic                clk,
    input  logic                arst_n,
    input  rvcore_pkg::inst_t   inst,
    output rvcore_pkg::xlen_t   pc,
    output logic                unknown_code,
    output rvcore_pkg::commit_t commit
);

    rvcore_pkg::ctrl_t ctrl;        // decoded control
    rvcore_pkg::xlen_t imm;         // sign-extended immediate
    rvcore_pkg::xlen_t reg1_rdata;
    rvcore_pkg::xlen_t reg2_rdata;
    rvcore_pkg::xlen_t alu_res;     // also the write-back value
    logic              br_taken;

    pc_unit u_pc_unit (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .ctrl       ( ctrl       ),
        .imm        ( imm        ),
        .reg1_rdata ( reg1_rdata ),
        .br_taken   ( br_taken   ),
        .pc         ( pc         )
    );

    inst_decoder u_inst_decoder (
        .inst         ( inst         ),
        .ctrl         ( ctrl         ),
        .imm          ( imm          ),
        .unknown_code ( unknown_code )
    );

    reg_file u_reg_file (
        .clk    ( clk             ),
        .arst_n ( arst_n          ),
        .wen    ( ctrl.reg_wen    ),
        .waddr  ( ctrl.reg_waddr  ),
        .wdata  ( alu_res         ),
        .raddr1 ( ctrl.reg1_raddr ),
        .raddr2 ( ctrl.reg2_raddr ),
        .rdata1 ( reg1_rdata      ),
        .rdata2 ( reg2_rdata      )
    );

    alu u_alu (
        .ctrl       ( ctrl       ),
        .reg1_rdata ( reg1_rdata ),
        .reg2_rdata ( reg2_rdata ),
        .imm        ( imm        ),
        .pc         ( pc         ),
        .alu_res    ( alu_res    ),
        .br_taken   ( br_taken   )
    );

    assign commit.valid     = arst_n;  // every edge out of reset retires one
    assign commit.reg_wen   = ctrl.reg_wen;
    assign commit.reg_waddr = ctrl.reg_waddr;
    assign commit.reg_wdata = alu_res;

endmodule

`default_nettype wire

/* tests/rvcore_tb.sv */
// self-checking testbench for rvcore_top, acts as instruction memory and runs a random program
`timescale 1ns/10ps
`default_nettype none

`include "rvcore_defines.svh"

module rvcore_tb;

    localparam int MEM_WORDS    = 256;
    localparam int BODY_END     = 230;  // random body stops growing here
    localparam int TAIL_WORDS   = 8;    // room for the longest forward offset
    localparam int RESET_CYCLES = 10;
    localparam int CYCLE_LIMIT  = 2 * MEM_WORDS + RESET_CYCLES;

    logic                  clk;
    logic                  arst_n;
    rvcore_pkg::inst_t     inst;
    rvcore_pkg::xlen_t     pc;
    logic                  unknown_code;
    rvcore_pkg::commit_t   commit;

    rvcore_pkg::inst_t     prog [0:MEM_WORDS-1];
    int                    prog_len;
    rvcore_pkg::xlen_t     end_pc;     // closing self-loop
    rvcore_pkg::xlen_t     fetch_off;  // byte offset of pc into prog

    rvcore_pkg::xlen_t     model_regs [0:31];
    rvcore_pkg::xlen_t     model_pc;
    string                 prev_name;

    logic                  exp_wen;
    rvcore_pkg::reg_addr_t exp_waddr;
    rvcore_pkg::xlen_t     exp_wdata;
    logic                  exp_unknown;
    rvcore_pkg::xlen_t     exp_next_pc;
    string                 exp_name;

    int                    errors;
    int                    cycles;
    int                    reset_edges;
    logic                  done;

    rvcore_top u_dut (
        .clk          ( clk          ),
        .arst_n       ( arst_n       ),
        .inst         ( inst         ),
        .pc           ( pc           ),
        .unknown_code ( unknown_code ),
        .commit       ( commit       )
    );

    always #10 clk = ~clk;  // 20 ns period

    function automatic rvcore_pkg::inst_t r_word(input logic [6:0] f7, input logic [2:0] f3,
                                                 input rvcore_pkg::reg_addr_t rd,
                                                 input rvcore_pkg::reg_addr_t rs1,
                                                 input rvcore_pkg::reg_addr_t rs2);
        return {f7, rs2, rs1, f3, rd, `OPC_OP};
    endfunction

    function automatic rvcore_pkg::inst_t i_word(input logic [11:0] imm, input logic [2:0] f3,
                                                 input rvcore_pkg::reg_addr_t rd,
                                                 input rvcore_pkg::reg_addr_t rs1,
                                                 input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic rvcore_pkg::inst_t u_word(input logic [19:0] imm,
                                                 input rvcore_pkg::reg_addr_t rd,
                                                 input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic rvcore_pkg::inst_t b_word(input logic [12:0] off, input logic [2:0] f3,
                                                 input rvcore_pkg::reg_addr_t rs1,
                                                 input rvcore_pkg::reg_addr_t rs2);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `OPC_BRANCH};
    endfunction

    function automatic rvcore_pkg::inst_t j_word(input logic [20:0] off,
                                                 input rvcore_pkg::reg_addr_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, `OPC_JAL};
    endfunction

    function automatic rvcore_pkg::reg_addr_t random_reg();
        return rvcore_pkg::reg_addr_t'($urandom_range(31, 0));
    endfunction

    function automatic logic [2:0] alu_funct3();
        case ($urandom_range(5, 0))
            0:       return 3'b000;
            1:       return 3'b010;
            2:       return 3'b011;
            3:       return 3'b100;
            4:       return 3'b110;
            default: return 3'b111;
        endcase
    endfunction

    function automatic logic [2:0] branch_funct3();
        case ($urandom_range(5, 0))
            0:       return 3'b000;
            1:       return 3'b001;
            2:       return 3'b100;
            3:       return 3'b101;
            4:       return 3'b110;
            default: return 3'b111;
        endcase
    endfunction

    // encodings outside the supported subset
    function automatic rvcore_pkg::inst_t unknown_word();
        rvcore_pkg::inst_t w;
        case ($urandom_range(5, 0))
            0:       w = {25'($urandom), 7'b0000011};                             // load
            1:       w = r_word(7'h00, 3'b001, random_reg(), random_reg(), random_reg()); // sll
            2:       w = r_word(7'h01, 3'b000, random_reg(), random_reg(), random_reg()); // mul
            3:       w = i_word(12'd3, 3'b001, random_reg(), random_reg(), `OPC_OP_IMM); // slli
            4:       w = b_word(13'd8, 3'b010, random_reg(), random_reg());
            default: w = i_word(12'd0, 3'b011, random_reg(), random_reg(), `OPC_JALR);
        endcase
        return w;
    endfunction

    task automatic emit(input rvcore_pkg::inst_t w);
        prog[prog_len[7:0]] = w;
        prog_len++;
    endtask

    task automatic build_program();
        rvcore_pkg::reg_addr_t rd;
        rvcore_pkg::reg_addr_t rs1;
        rvcore_pkg::reg_addr_t rs2;
        rvcore_pkg::reg_addr_t link;
        logic [2:0]            f3;
        int                    off;
        logic                  landed [0:MEM_WORDS-1];  // word is the target of some jump
        prog_len = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            landed[i] = 1'b0;
        end
        for (int r = 1; r < 32; r++) begin  // full-width start values
            emit(u_word(20'($urandom), 5'(r), `OPC_LUI));
            emit(i_word(12'($urandom), 3'b000, 5'(r), 5'(r), `OPC_OP_IMM));
        end
        emit(i_word(12'd5, 3'b000, 5'd0, 5'd1, `OPC_OP_IMM));  // write to x0
        emit(r_word(7'h00, 3'b000, 5'd2, 5'd0, 5'd3));         // read of x0
        while (prog_len < BODY_END) begin
            rd  = random_reg();
            rs1 = random_reg();
            rs2 = ($urandom_range(3, 0) == 0) ? rs1 : random_reg();
            f3  = alu_funct3();
            case ($urandom_range(15, 0))
                0, 1, 2, 3: emit(r_word((f3 == 3'b000 && $urandom_range(1, 0) == 1) ?
                                        7'h20 : 7'h00, f3, rd, rs1, rs2));
                4, 5, 6:    emit(i_word(12'($urandom), f3, rd, rs1, `OPC_OP_IMM));
                7:          emit(u_word(20'($urandom), rd, `OPC_LUI));
                8:          emit(u_word(20'($urandom), rd, `OPC_AUIPC));
                9:          emit(unknown_word());
                10, 11: begin
                    off = 4 * $urandom_range(8, 2);
                    landed[prog_len + off / 4] = 1'b1;
                    emit(b_word(13'(off), branch_funct3(), rs1, rs2));
                end
                12: begin
                    off = 4 * $urandom_range(8, 2);
                    landed[prog_len + off / 4] = 1'b1;
                    emit(j_word(21'(off), rd));
                end
                13: begin
                    link = rvcore_pkg::reg_addr_t'($urandom_range(31, 1));
                    off  = 4 * $urandom_range(9, 2);
                    emit(u_word(20'd0, link, `OPC_AUIPC));
                    // no jalr on a jump target since its auipc would be skipped
                    if (!landed[prog_len]) begin
                        landed[prog_len - 1 + off / 4] = 1'b1;
                        // odd offsets too, target lsb gets cleared
                        emit(i_word(12'(off + $urandom_range(1, 0)), 3'b000,
                                    rd, link, `OPC_JALR));
                    end
                end
                14:         emit(r_word(7'h00, f3, 5'd0, rs1, rs2));
                default:    emit(i_word(12'($urandom), f3, rd, 5'd0, `OPC_OP_IMM));
            endcase
        end
        repeat (TAIL_WORDS) begin
            emit(r_word(7'h00, alu_funct3(), random_reg(), random_reg(), random_reg()));
        end
        end_pc = `RESET_PC + 64'(4 * prog_len);
        emit(j_word(21'd0, 5'd0));  // end marker, jumps to itself
    endtask

    // architectural result of one instruction from the model state
    task automatic predict(input rvcore_pkg::inst_t w);
        logic [6:0]        opc;
        logic [2:0]        f3;
        logic [6:0]        f7;
        logic              writes;
        logic              taken;
        rvcore_pkg::xlen_t a;
        rvcore_pkg::xlen_t b;
        rvcore_pkg::xlen_t opnd;
        rvcore_pkg::xlen_t imm_i;
        rvcore_pkg::xlen_t imm_u;
        rvcore_pkg::xlen_t imm_b;
        rvcore_pkg::xlen_t imm_j;
        opc   = w[6:0];
        f3    = w[14:12];
        f7    = w[31:25];
        a     = model_regs[w[19:15]];
        b     = model_regs[w[24:20]];
        imm_i = rvcore_pkg::xlen_t'($signed(w[31:20]));
        imm_u = rvcore_pkg::xlen_t'($signed({w[31:12], 12'h000}));
        imm_b = rvcore_pkg::xlen_t'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
        imm_j = rvcore_pkg::xlen_t'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
        writes      = 1'b0;
        taken       = 1'b0;
        exp_unknown = 1'b0;
        exp_wdata   = '0;
        exp_next_pc = model_pc + 64'd4;
        exp_name    = "unknown";
        case (opc)
            `OPC_OP, `OPC_OP_IMM: begin
                writes   = 1'b1;
                opnd     = (opc == `OPC_OP) ? b : imm_i;
                exp_name = (opc == `OPC_OP) ? "reg alu" : "imm alu";
                if (opc == `OPC_OP && !(f7 == 7'h00 || (f7 == 7'h20 && f3 == 3'b000))) begin
                    exp_unknown = 1'b1;
                end
                case (f3)
                    3'b000:  exp_wdata = (opc == `OPC_OP && f7[5]) ? a - opnd : a + opnd;
                    3'b010:  exp_wdata = {63'b0, $signed(a) < $signed(opnd)};
                    3'b011:  exp_wdata = {63'b0, a < opnd};
                    3'b100:  exp_wdata = a ^ opnd;
                    3'b110:  exp_wdata = a | opnd;
                    3'b111:  exp_wdata = a & opnd;
                    default: exp_unknown = 1'b1;  // shifts
                endcase
            end
            `OPC_LUI: begin
                writes    = 1'b1;
                exp_name  = "lui";
                exp_wdata = imm_u;
            end
            `OPC_AUIPC: begin
                writes    = 1'b1;
                exp_name  = "auipc";
                exp_wdata = model_pc + imm_u;
            end
            `OPC_JAL: begin
                writes      = 1'b1;
                exp_name    = "jal";
                exp_wdata   = model_pc + 64'd4;
                exp_next_pc = model_pc + imm_j;
            end
            `OPC_JALR: begin
                if (f3 == 3'b000) begin
                    writes      = 1'b1;
                    exp_name    = "jalr";
                    exp_wdata   = model_pc + 64'd4;
                    exp_next_pc = (a + imm_i) & ~64'd1;
                end else begin
                    exp_unknown = 1'b1;
                end
            end
            `OPC_BRANCH: begin
                exp_name = "branch";
                case (f3)
                    3'b000:  taken = (a == b);
                    3'b001:  taken = (a != b);
                    3'b100:  taken = ($signed(a) < $signed(b));
                    3'b101:  taken = ($signed(a) >= $signed(b));
                    3'b110:  taken = (a < b);
                    3'b111:  taken = (a >= b);
                    default: exp_unknown = 1'b1;
                endcase
                if (taken) begin
                    exp_next_pc = model_pc + imm_b;
                end
            end
            default: exp_unknown = 1'b1;
        endcase
        if (exp_unknown) begin
            exp_name = "unknown";
        end else if (writes && w[11:7] == 5'd0) begin
            exp_name = {exp_name, " to x0"};
        end
        exp_waddr = w[11:7];
        exp_wen   = writes && !exp_unknown && (w[11:7] != 5'd0);
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected)
        else begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // instruction memory, answers the pc of this cycle
    always @(negedge clk) begin
        fetch_off = pc - `RESET_PC;
        if (pc >= `RESET_PC && pc <= end_pc && pc[1:0] == 2'b00) begin
            inst = prog[fetch_off[9:2]];
        end else begin
            errors++;
            $display("pc %h left the program, a no-op is fetched", pc);
            inst = 32'h0000_0013;
        end
    end

    always @(posedge clk) begin
        if (!arst_n) begin
            reset_edges++;
            if (reset_edges > 1) begin  // pc holds its reset value from the second edge on
                check_value("reset pc", `RESET_PC, pc);
            end
            check_value("reset commit valid", 64'd0, 64'(commit.valid));
        end else if (!done) begin
            cycles++;
            check_value({"next pc after ", prev_name}, model_pc, pc);
            if (model_pc == end_pc) begin
                done = 1'b1;
            end else begin
                predict(inst);
                check_value({exp_name, " valid"}, 64'd1, 64'(commit.valid));
                check_value({exp_name, " unknown_code"}, 64'(exp_unknown), 64'(unknown_code));
                check_value({exp_name, " reg_wen"}, 64'(exp_wen), 64'(commit.reg_wen));
                if (exp_wen) begin
                    check_value({exp_name, " reg_waddr"}, 64'(exp_waddr),
                                64'(commit.reg_waddr));
                    check_value({exp_name, " reg_wdata"}, exp_wdata, commit.reg_wdata);
                    model_regs[exp_waddr] = exp_wdata;
                end
                model_pc  = exp_next_pc;
                prev_name = exp_name;
            end
        end
    end

    initial begin
        void'($urandom(32'h7315_2725));
        clk         = 1'b0;
        arst_n      = 1'b0;
        inst        = '0;
        errors      = 0;
        cycles      = 0;
        reset_edges = 0;
        done        = 1'b0;
        prev_name   = "reset";
        model_pc    = `RESET_PC;
        for (int i = 0; i < 32; i++) begin
            model_regs[i[4:0]] = '0;
        end
        build_program();
        repeat (RESET_CYCLES) @(negedge clk);
        arst_n = 1'b1;
        wait (done || cycles >= CYCLE_LIMIT);
        if (!done) begin
            errors++;
            $display("timeout: program never reached its end marker in %0d cycles", cycles);
        end
        $display("errors: %0d, retired cycles: %0d", errors, cycles);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+verilog
verilog/rvcore_pkg.sv
verilog/pc_unit.sv
verilog/inst_decoder.sv
verilog/reg_file.sv
verilog/alu.sv
verilog/rvcore_top.sv
tests/rvcore_tb.sv
